/* src/sparcAlu_cfg.svh */
`ifndef SPARC_ALU_CFG_SVH
`define SPARC_ALU_CFG_SVH

// Cluster sizing

// Hardware threads, one ALU lane each
`define SPARC_ALU_NUM_THREADS 4

// Integer data path width
`define SPARC_ALU_XLEN 32

// Shift count bits taken from operand b
`define SPARC_ALU_SHAMT_W 5

`endif

/* src/isaPkg.sv */
`include "sparcAlu_cfg.svh"

package isaPkg;

	// Integer operand or result
	typedef logic [`SPARC_ALU_XLEN-1:0] word_t;

	// Raw op3 style operation field
	typedef logic [5:0] opcode_t;

	// Shift count, low bits of operand b only
	typedef logic [`SPARC_ALU_SHAMT_W-1:0] shamt_t;

	// Decoded ALU operation
	// The cc form is carried separately as a flag
	typedef enum logic [3:0]
	{
		OP_ADD,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SUB,
		OP_ANDN,
		OP_ORN,
		OP_XNOR,
		OP_ADDX,
		OP_SUBX,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_ILLEGAL
	} aluOp_e;

	// Integer condition codes
	typedef struct packed
	{
		// Negative
		logic n;
		// Zero
		logic z;
		// Overflow
		logic v;
		// Carry or borrow
		logic c;
	} icc_t;

endpackage

/* src/pipePkg.sv */
`include "sparcAlu_cfg.svh"

package pipePkg;

	import isaPkg::*;

	// Hardware thread number
	typedef logic [$clog2(`SPARC_ALU_NUM_THREADS)-1:0] threadId_t;

	// Request as seen on the cluster input port
	typedef struct packed
	{
		threadId_t thread;
		opcode_t opcode;
		word_t a;
		word_t b;
	} aluReq_t;

	// Decoded command broadcast to every lane
	typedef struct packed
	{
		aluOp_e op;
		// Write the thread flags
		logic setCc;
		word_t a;
		word_t b;
	} laneCmd_t;

	// Response from a lane or the cluster
	typedef struct packed
	{
		threadId_t thread;
		word_t result;
		icc_t icc;
		logic illegal;
	} aluResp_t;

endpackage

/* src/threadDispatch.sv */
`timescale 1ns/1ps
`include "sparcAlu_cfg.svh"

module threadDispatch
(
	input logic clk,
	input logic rst,
	input logic reqValid,
	input pipePkg::aluReq_t req,
	output pipePkg::laneCmd_t cmd,
	output logic [`SPARC_ALU_NUM_THREADS-1:0] laneStrobe
);
	import isaPkg::*;
	import pipePkg::*;

	aluOp_e decOp;
	// Operation has a flag setting form
	logic ccCapable;
	logic [`SPARC_ALU_NUM_THREADS-1:0] nextStrobe;

	// Opcode decode, bit 4 is the cc select and is a don't care here
	always_comb
	begin
		ccCapable = 1'b1;
		casez (req.opcode)
			6'b0?0000: decOp = OP_ADD;
			6'b0?0001: decOp = OP_AND;
			6'b0?0010: decOp = OP_OR;
			6'b0?0011: decOp = OP_XOR;
			6'b0?0100: decOp = OP_SUB;
			6'b0?0101: decOp = OP_ANDN;
			6'b0?0110: decOp = OP_ORN;
			6'b0?0111: decOp = OP_XNOR;
			6'b0?1000: decOp = OP_ADDX;
			6'b0?1100: decOp = OP_SUBX;
			// Shifts have no cc form
			6'b100101:
			begin
				decOp = OP_SLL;
				ccCapable = 1'b0;
			end
			6'b100110:
			begin
				decOp = OP_SRL;
				ccCapable = 1'b0;
			end
			6'b100111:
			begin
				decOp = OP_SRA;
				ccCapable = 1'b0;
			end
			default:
			begin
				decOp = OP_ILLEGAL;
				ccCapable = 1'b0;
			end
		endcase
	end

	// Lane select from the thread field
	always_comb
	begin
		for (int i = 0; i < `SPARC_ALU_NUM_THREADS; i++)
		begin
			nextStrobe[i] = reqValid && (req.thread == threadId_t'(i));
		end
	end

	// Command payload, only loaded on a request
	always_ff @(posedge clk)
	begin
		if (reqValid)
		begin
			cmd.op <= decOp;
			cmd.setCc <= ccCapable && req.opcode[4];
			cmd.a <= req.a;
			cmd.b <= req.b;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			laneStrobe <= '0;
		end
		else
		begin
			laneStrobe <= nextStrobe;
		end
	end

	// At most one lane gets the command
	assert property (@(posedge clk) disable iff (rst) $onehot0(laneStrobe))
	else $error("laneStrobe not one-hot");

endmodule

/* src/threadAlu.sv */
`timescale 1ns/1ps
`include "sparcAlu_cfg.svh"

module threadAlu
(
	input logic clk,
	input logic rst,
	input logic strobe,
	input pipePkg::laneCmd_t cmd,
	output logic doneValid,
	output pipePkg::aluResp_t laneOut
);
	import isaPkg::*;
	import pipePkg::*;

	// Sign bit position
	localparam int msb = `SPARC_ALU_XLEN - 1;

	// This thread's condition codes
	icc_t iccQ;

	// Operands widened by one bit to catch carry and borrow
	logic [`SPARC_ALU_XLEN:0] aExt;
	logic [`SPARC_ALU_XLEN:0] bExt;
	// Stored C as a full width addend
	logic [`SPARC_ALU_XLEN:0] carryIn;

	shamt_t shamt;
	word_t result;
	// Carry out or borrow out of bit msb
	logic carry;
	// Flag rule select
	logic addCc;
	logic subCc;
	icc_t nextIcc;

	assign aExt = {1'b0, cmd.a};
	assign bExt = {1'b0, cmd.b};
	assign carryIn = {{`SPARC_ALU_XLEN{1'b0}}, iccQ.c};

	// Upper bits of b are ignored for shifts
	assign shamt = cmd.b[`SPARC_ALU_SHAMT_W-1:0];

	// Result and carry
	always_comb
	begin
		result = '0;
		carry = 1'b0;
		addCc = 1'b0;
		subCc = 1'b0;
		case (cmd.op)
			OP_ADD:
			begin
				{carry, result} = aExt + bExt;
				addCc = 1'b1;
			end
			OP_ADDX:
			begin
				// Carry in from this thread only
				{carry, result} = aExt + bExt + carryIn;
				addCc = 1'b1;
			end
			OP_SUB:
			begin
				// Bit msb+1 of the wide difference is the borrow
				{carry, result} = aExt - bExt;
				subCc = 1'b1;
			end
			OP_SUBX:
			begin
				{carry, result} = aExt - bExt - carryIn;
				subCc = 1'b1;
			end
			OP_AND:
			begin
				result = cmd.a & cmd.b;
			end
			OP_OR:
			begin
				result = cmd.a | cmd.b;
			end
			OP_XOR:
			begin
				result = cmd.a ^ cmd.b;
			end
			// Inverted second operand forms
			OP_ANDN:
			begin
				result = cmd.a & ~cmd.b;
			end
			OP_ORN:
			begin
				result = cmd.a | ~cmd.b;
			end
			OP_XNOR:
			begin
				result = cmd.a ^ ~cmd.b;
			end
			OP_SLL:
			begin
				result = cmd.a << shamt;
			end
			OP_SRL:
			begin
				result = cmd.a >> shamt;
			end
			OP_SRA:
			begin
				// Sign fill from bit msb
				result = word_t'($signed(cmd.a) >>> shamt);
			end
			default:
			begin
				// Illegal op gives zero
				result = '0;
			end
		endcase
	end

	// Condition codes after this instruction
	always_comb
	begin
		nextIcc = iccQ;
		if (cmd.setCc)
		begin
			nextIcc.n = result[msb];
			nextIcc.z = (result == '0);
			if (addCc)
			begin
				// Like signs in, other sign out
				nextIcc.v = (cmd.a[msb] == cmd.b[msb]) && (result[msb] != cmd.a[msb]);
				nextIcc.c = carry;
			end
			else if (subCc)
			begin
				// Unlike signs in, sign of a lost
				nextIcc.v = (cmd.a[msb] != cmd.b[msb]) && (result[msb] != cmd.a[msb]);
				nextIcc.c = carry;
			end
			else
			begin
				// Logic ops clear V and C
				nextIcc.v = 1'b0;
				nextIcc.c = 1'b0;
			end
		end
	end

	// Flags and done strobe
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			iccQ <= '0;
			doneValid <= 1'b0;
		end
		else
		begin
			doneValid <= strobe;
			if (strobe && cmd.setCc)
			begin
				iccQ <= nextIcc;
			end
		end
	end

	// Lane output, thread field filled in by the collector
	always_ff @(posedge clk)
	begin
		if (strobe)
		begin
			laneOut.thread <= '0;
			laneOut.result <= result;
			laneOut.icc <= nextIcc;
			laneOut.illegal <= (cmd.op == OP_ILLEGAL);
		end
	end

	// Decoder must never mark an unknown opcode as flag setting
	assert property (@(posedge clk) disable iff (rst)
		strobe && (cmd.op == OP_ILLEGAL) |-> !cmd.setCc)
	else $error("illegal command with setCc");

endmodule

/* src/resultCollect.sv */
`timescale 1ns/1ps
`include "sparcAlu_cfg.svh"

module resultCollect
(
	input logic clk,
	input logic rst,
	input logic [`SPARC_ALU_NUM_THREADS-1:0] doneValid,
	input pipePkg::aluResp_t laneOut [`SPARC_ALU_NUM_THREADS],
	output logic respValid,
	output pipePkg::aluResp_t resp
);
	import pipePkg::*;

	aluResp_t selResp;
	logic anyDone;

	// Pick the finishing lane and stamp its index
	always_comb
	begin
		selResp = '0;
		anyDone = 1'b0;
		for (int i = 0; i < `SPARC_ALU_NUM_THREADS; i++)
		begin
			if (doneValid[i])
			begin
				selResp = laneOut[i];
				selResp.thread = threadId_t'(i);
				anyDone = 1'b1;
			end
		end
	end

	// Response payload
	always_ff @(posedge clk)
	begin
		if (anyDone)
		begin
			resp <= selResp;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			respValid <= 1'b0;
		end
		else
		begin
			respValid <= anyDone;
		end
	end

	// Lanes finish one at a time, so there is no merge conflict
	assert property (@(posedge clk) disable iff (rst) $onehot0(doneValid))
	else $error("lane done strobes collide");

endmodule

/* src/sparcAluCluster.sv */
`timescale 1ns/1ps
`include "sparcAlu_cfg.svh"

module sparcAluCluster
(
	input logic clk,
	input logic rst,
	input logic reqValid,
	input pipePkg::aluReq_t req,
	output logic respValid,
	output pipePkg::aluResp_t resp
);
	import pipePkg::*;

	// Shared command bus and per lane strobes
	laneCmd_t cmd;
	logic [`SPARC_ALU_NUM_THREADS-1:0] laneStrobe;

	// Lane results
	logic [`SPARC_ALU_NUM_THREADS-1:0] doneValid;
	aluResp_t laneOut [`SPARC_ALU_NUM_THREADS];

	// Stage 1, decode and steer
	threadDispatch dispatch0
	(
		.clk(clk),
		.rst(rst),
		.reqValid(reqValid),
		.req(req),
		.cmd(cmd),
		.laneStrobe(laneStrobe)
	);

	// Stage 2, one lane per thread
	for (genvar g = 0; g < `SPARC_ALU_NUM_THREADS; g++)
	begin : genLane
		threadAlu lane
		(
			.clk(clk),
			.rst(rst),
			.strobe(laneStrobe[g]),
			.cmd(cmd),
			.doneValid(doneValid[g]),
			.laneOut(laneOut[g])
		);
	end

	// Stage 3, merge into the response port
	resultCollect collect0
	(
		.clk(clk),
		.rst(rst),
		.doneValid(doneValid),
		.laneOut(laneOut),
		.respValid(respValid),
		.resp(resp)
	);

endmodule

/* verif/sparcAluClusterTb.sv */
`timescale 1ns/1ps
`include "sparcAlu_cfg.svh"

module sparcAluClusterTb;
	import isaPkg::*;
	import pipePkg::*;

	// Falling edges from driving a request to seeing its response
	localparam int respLatency = 3;
	// Falling edges allowed for the pipeline to drain
	localparam int waitLimit = 20;
	localparam int randomCount = 200;

	// One stimulus line with its expected response
	typedef struct packed
	{
		threadId_t thread;
		opcode_t opcode;
		word_t a;
		word_t b;
		word_t expResult;
		icc_t expIcc;
		logic expIllegal;
	} tableEntry_t;

	logic clk;
	logic rst;
	logic reqValid;
	aluReq_t req;
	logic respValid;
	aluResp_t resp;

	tableEntry_t directed[$];
	// Requests in flight and the cycle each was driven
	tableEntry_t pending[$];
	int pendingCycle[$];
	// Reference flags per thread
	icc_t modelIcc [`SPARC_ALU_NUM_THREADS];
	logic [31:0] lfsrState;
	int cycleCount = 0;

	// Legal codes plus a few illegal ones for random picks
	opcode_t randomOps [26] = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07,
		6'h08, 6'h0c, 6'h10, 6'h11, 6'h12, 6'h13, 6'h14, 6'h15, 6'h16, 6'h17,
		6'h18, 6'h1c, 6'h25, 6'h26, 6'h27, 6'h09, 6'h3f, 6'h35};

	sparcAluCluster dut0
	(
		.clk(clk),
		.rst(rst),
		.reqValid(reqValid),
		.req(req),
		.respValid(respValid),
		.resp(resp)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			stopWithFailure($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got,
				expected));
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic nextLfsrBit();
		logic feedback;
		feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], feedback};
		return feedback;
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[30:0], nextLfsrBit()};
		end
		return value;
	endfunction

	// Reference ALU from the instruction rules
	function automatic tableEntry_t modelEntry(input threadId_t thread, input opcode_t opcode,
		input word_t a, input word_t b);
		tableEntry_t e;
		icc_t flags;
		logic [63:0] sum;
		logic cin;
		logic carry;
		logic legal;
		logic isAdd;
		logic isSub;
		e = '0;
		e.thread = thread;
		e.opcode = opcode;
		e.a = a;
		e.b = b;
		flags = modelIcc[thread];
		cin = 1'b0;
		legal = 1'b1;
		isAdd = 1'b0;
		isSub = 1'b0;
		if (opcode[5])
		begin
			// Shift group with the count from b[4:0]
			case (opcode)
				6'h25: e.expResult = a << b[4:0];
				6'h26: e.expResult = a >> b[4:0];
				// Vacated upper bits take the sign of a
				6'h27: e.expResult = (a >> b[4:0]) |
					(a[31] ? ~(32'hffffffff >> b[4:0]) : 32'h0);
				default: legal = 1'b0;
			endcase
		end
		else
		begin
			case (opcode[3:0])
				4'h0: isAdd = 1'b1;
				4'h1: e.expResult = a & b;
				4'h2: e.expResult = a | b;
				4'h3: e.expResult = a ^ b;
				4'h4: isSub = 1'b1;
				4'h5: e.expResult = a & ~b;
				4'h6: e.expResult = a | ~b;
				4'h7: e.expResult = ~(a ^ b);
				4'h8:
				begin
					isAdd = 1'b1;
					cin = flags.c;
				end
				4'hc:
				begin
					isSub = 1'b1;
					cin = flags.c;
				end
				default: legal = 1'b0;
			endcase
		end
		// Carry from a 64 bit sum and borrow from a magnitude compare
		sum = 64'(a) + 64'(b) + 64'(cin);
		carry = 1'b0;
		if (isAdd)
		begin
			e.expResult = sum[31:0];
			carry = sum[32];
		end
		if (isSub)
		begin
			e.expResult = a - b - word_t'(cin);
			carry = (64'(a) < 64'(b) + 64'(cin));
		end
		// Bit 4 picks the cc form which shifts never have
		if (legal && opcode[4])
		begin
			flags.n = e.expResult[31];
			flags.z = (e.expResult == 32'd0);
			flags.v = 1'b0;
			flags.c = carry;
			if (isAdd)
			begin
				flags.v = (a[31] == b[31]) && (e.expResult[31] != a[31]);
			end
			if (isSub)
			begin
				flags.v = (a[31] != b[31]) && (e.expResult[31] != a[31]);
			end
		end
		modelIcc[thread] = flags;
		e.expIcc = flags;
		e.expIllegal = !legal;
		return e;
	endfunction

	// Hand computed line that also moves the reference flags along
	function automatic void addDirected(input threadId_t thread, input opcode_t opcode,
		input word_t a, input word_t b, input word_t result, input icc_t icc, input logic ill);
		tableEntry_t e;
		e.thread = thread;
		e.opcode = opcode;
		e.a = a;
		e.b = b;
		e.expResult = result;
		e.expIcc = icc;
		e.expIllegal = ill;
		directed.push_back(e);
		modelIcc[thread] = icc;
	endfunction

	// icc column is {n, z, v, c}
	function automatic void loadDirected();
		// Plain forms showing all flags zero out of reset
		addDirected(2'd0, 6'h00, 32'h00000005, 32'h00000007, 32'h0000000c, 4'h0, 1'b0);
		addDirected(2'd1, 6'h01, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000, 4'h0, 1'b0);
		addDirected(2'd2, 6'h02, 32'h12340000, 32'h00005678, 32'h12345678, 4'h0, 1'b0);
		addDirected(2'd3, 6'h03, 32'hffff0000, 32'h0ff00ff0, 32'hf00f0ff0, 4'h0, 1'b0);
		addDirected(2'd0, 6'h04, 32'h0000000a, 32'h00000003, 32'h00000007, 4'h0, 1'b0);
		addDirected(2'd1, 6'h05, 32'hffffffff, 32'h0000ffff, 32'hffff0000, 4'h0, 1'b0);
		addDirected(2'd2, 6'h06, 32'h00000000, 32'hfffffff0, 32'h0000000f, 4'h0, 1'b0);
		addDirected(2'd3, 6'h07, 32'haaaaaaaa, 32'h55555555, 32'h00000000, 4'h0, 1'b0);
		// Shift counts use b[4:0] only
		addDirected(2'd0, 6'h25, 32'h00000001, 32'h00000021, 32'h00000002, 4'h0, 1'b0);
		addDirected(2'd1, 6'h26, 32'h80000000, 32'h00000004, 32'h08000000, 4'h0, 1'b0);
		addDirected(2'd2, 6'h27, 32'h80000000, 32'h0000003f, 32'hffffffff, 4'h0, 1'b0);
		// cc forms
		addDirected(2'd0, 6'h10, 32'hffffffff, 32'h00000001, 32'h00000000, 4'h5, 1'b0);
		addDirected(2'd1, 6'h10, 32'h7fffffff, 32'h00000001, 32'h80000000, 4'ha, 1'b0);
		addDirected(2'd2, 6'h14, 32'h00000000, 32'h00000001, 32'hffffffff, 4'h9, 1'b0);
		addDirected(2'd3, 6'h14, 32'h80000000, 32'h00000001, 32'h7fffffff, 4'h2, 1'b0);
		addDirected(2'd0, 6'h11, 32'h80000000, 32'h80000001, 32'h80000000, 4'h8, 1'b0);
		addDirected(2'd1, 6'h12, 32'h00000000, 32'h00000000, 32'h00000000, 4'h4, 1'b0);
		addDirected(2'd2, 6'h13, 32'h00000005, 32'h00000005, 32'h00000000, 4'h4, 1'b0);
		addDirected(2'd3, 6'h15, 32'hffffffff, 32'h00000000, 32'hffffffff, 4'h8, 1'b0);
		addDirected(2'd0, 6'h16, 32'h00000000, 32'hffffffff, 32'h00000000, 4'h4, 1'b0);
		addDirected(2'd1, 6'h17, 32'h00000000, 32'h00000000, 32'hffffffff, 4'h8, 1'b0);
		// Plain forms and shifts keep nonzero flags
		addDirected(2'd2, 6'h00, 32'hffffffff, 32'h00000001, 32'h00000000, 4'h4, 1'b0);
		addDirected(2'd3, 6'h25, 32'h00000001, 32'h0000001e, 32'h40000000, 4'h8, 1'b0);
		addDirected(2'd1, 6'h04, 32'h00000000, 32'h00000001, 32'hffffffff, 4'h8, 1'b0);
		addDirected(2'd0, 6'h27, 32'hf0000000, 32'h00000004, 32'hff000000, 4'h4, 1'b0);
		// Carry chains where neighbours hold the opposite C
		addDirected(2'd0, 6'h10, 32'hffffffff, 32'hffffffff, 32'hfffffffe, 4'h9, 1'b0);
		addDirected(2'd1, 6'h10, 32'h00000001, 32'h00000001, 32'h00000002, 4'h0, 1'b0);
		addDirected(2'd1, 6'h18, 32'hffffffff, 32'h00000000, 32'hffffffff, 4'h8, 1'b0);
		addDirected(2'd0, 6'h18, 32'h00000000, 32'h00000000, 32'h00000001, 4'h0, 1'b0);
		addDirected(2'd2, 6'h14, 32'h00000000, 32'h00000001, 32'hffffffff, 4'h9, 1'b0);
		addDirected(2'd3, 6'h14, 32'h00000005, 32'h00000003, 32'h00000002, 4'h0, 1'b0);
		addDirected(2'd2, 6'h0c, 32'h00000010, 32'h00000003, 32'h0000000c, 4'h9, 1'b0);
		addDirected(2'd3, 6'h0c, 32'h00000010, 32'h00000003, 32'h0000000d, 4'h0, 1'b0);
		addDirected(2'd2, 6'h1c, 32'h00000005, 32'h00000005, 32'hffffffff, 4'h9, 1'b0);
		addDirected(2'd3, 6'h1c, 32'h00000005, 32'h00000005, 32'h00000000, 4'h4, 1'b0);
		addDirected(2'd2, 6'h18, 32'hffffffff, 32'h00000000, 32'h00000000, 4'h5, 1'b0);
		addDirected(2'd0, 6'h08, 32'h00000010, 32'h00000020, 32'h00000030, 4'h0, 1'b0);
		addDirected(2'd2, 6'h08, 32'h00000001, 32'h00000001, 32'h00000003, 4'h5, 1'b0);
		// Illegal codes give zero and keep the flags
		addDirected(2'd1, 6'h3f, 32'h00001234, 32'h00005678, 32'h00000000, 4'h8, 1'b1);
		addDirected(2'd3, 6'h09, 32'hffffffff, 32'hffffffff, 32'h00000000, 4'h4, 1'b1);
		addDirected(2'd2, 6'h35, 32'h00000001, 32'h00000001, 32'h00000000, 4'h5, 1'b1);
		addDirected(2'd0, 6'h2c, 32'h80000000, 32'h00000001, 32'h00000000, 4'h0, 1'b1);
	endfunction

	// Called on a falling edge before any new drive
	task automatic sampleResponse();
		tableEntry_t e;
		int issued;
		string tag;
		if (respValid !== 1'b0)
		begin
			if (pending.size() == 0)
			begin
				stopWithFailure("Response strobe seen with no request in flight");
			end
			else
			begin
				e = pending.pop_front();
				issued = pendingCycle.pop_front();
				tag = $sformatf("op %h on thread %0d", e.opcode, e.thread);
				checkValue({tag, " latency"}, 32'(cycleCount - issued), 32'(respLatency));
				checkValue({tag, " thread"}, 32'(resp.thread), 32'(e.thread));
				checkValue({tag, " result"}, resp.result, e.expResult);
				checkValue({tag, " icc"}, 32'(resp.icc), 32'(e.expIcc));
				checkValue({tag, " illegal"}, 32'(resp.illegal), 32'(e.expIllegal));
			end
		end
	endtask

	task automatic issueEntry(input tableEntry_t e);
		reqValid = 1'b1;
		req.thread = e.thread;
		req.opcode = e.opcode;
		req.a = e.a;
		req.b = e.b;
		pending.push_back(e);
		pendingCycle.push_back(cycleCount);
	endtask

	// Idle the port until every request has answered
	task automatic drainResponses();
		int waitCount;
		waitCount = 0;
		while (pending.size() != 0 && waitCount < waitLimit)
		begin
			@(negedge clk);
			sampleResponse();
			reqValid = 1'b0;
			waitCount++;
		end
		if (pending.size() != 0)
		begin
			stopWithFailure("Timed out waiting for a response strobe");
		end
	endtask

	initial
	begin
		threadId_t thread;
		opcode_t opcode;
		word_t a;
		word_t b;
		rst = 1'b1;
		reqValid = 1'b0;
		req = '0;
		lfsrState = 32'hf857356e;
		for (int i = 0; i < `SPARC_ALU_NUM_THREADS; i++)
		begin
			modelIcc[i] = '0;
		end
		loadDirected();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// No response strobe right after reset
		repeat (4)
		begin
			@(negedge clk);
			sampleResponse();
		end
		// Directed lines one at a time
		foreach (directed[i])
		begin
			@(negedge clk);
			sampleResponse();
			issueEntry(directed[i]);
			drainResponses();
		end
		// Random lines on every cycle
		for (int i = 0; i < randomCount; i++)
		begin
			@(negedge clk);
			sampleResponse();
			thread = threadId_t'(randomBits(2));
			opcode = randomOps[int'(randomBits(5)) % 26];
			a = randomBits(32);
			b = randomBits(32);
			// Equal operands now and then to reach Z
			if (randomBits(2) == 32'd0)
			begin
				b = a;
			end
			issueEntry(modelEntry(thread, opcode, a, b));
		end
		drainResponses();
		// No extra strobes once the pipe is empty
		repeat (5)
		begin
			@(negedge clk);
			sampleResponse();
		end
		$display("Test OK");
		$finish;
	end

endmodule

/* sparcAluCluster.f */
+incdir+src
src/isaPkg.sv
src/pipePkg.sv
src/threadDispatch.sv
src/threadAlu.sv
src/resultCollect.sv
src/sparcAluCluster.sv
verif/sparcAluClusterTb.sv

/* Makefile */
# Verilator build for the ALU cluster testbench

VERILATOR ?= verilator
TOP ?= sparcAluClusterTb
FILELIST ?= sparcAluCluster.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
PASS_TEXT ?= Test OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := src/sparcAlu_cfg.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
